// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_myo_control --Mdir obj_dir -o sim_myo_control \
	&& ./obj_dir/sim_myo_control > sim.log 2>&1 ; cat sim.log \
	&& grep -q "Result: PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== src/myo_control_top.sv ====
// motor-board controller top, the SPI bit and frame engine sits outside on the frame port
// NUMBER_OF_MOTORS may be at most 254
`default_nettype none

module myo_control_top #(
	parameter int NUMBER_OF_MOTORS = 6,
	parameter int CLOCK_SPEED_HZ   = 50_000_000,
	parameter int POWER_ON_DELAY   = 150_000_000
) (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic [15:0]            address_i,
	input  wire logic                   read_i,
	input  wire logic                   write_i,
	input  wire logic [31:0]            writedata_i,
	input  wire logic                   frame_done_i,
	input  wire myo_pkg::frame_rx_t     frame_rx_i,
	input  wire logic                   ss_n_i,
	input  wire logic                   mirrored_muscle_unit_i,
	input  wire logic                   power_sense_n_i,
	output logic [31:0]                 readdata_o,
	output logic                        waitrequest_o,
	output logic                        frame_start_o,
	output logic [myo_pkg::PWM_W-1:0]   frame_pwm_o,
	output logic                        link_reset_o,
	output logic [NUMBER_OF_MOTORS-1:0] ss_n_o
);
	import myo_pkg::*;

	logic             spi_activated;
	logic [31:0]      update_frequency;
	logic [PWM_W-1:0] pwm_refs [NUMBER_OF_MOTORS];
	telemetry_t       telemetry [NUMBER_OF_MOTORS];
	logic [31:0]      actual_freq;
	motor_idx_t       active_motor;
	logic             latch;
	motor_idx_t       latch_motor;
	logic             link_reset_req;
	logic             power_good;

	myo_reg_bank #(
		.NUMBER_OF_MOTORS(NUMBER_OF_MOTORS)
	) i_reg_bank (
		.clock              (clock),
		.reset              (reset),
		.address_i          (address_i),
		.read_i             (read_i),
		.write_i            (write_i),
		.writedata_i        (writedata_i),
		.power_sense_n_i    (power_sense_n_i),
		.telemetry_i        (telemetry),
		.actual_freq_i      (actual_freq),
		.active_motor_i     (active_motor),
		.power_good_i       (power_good),
		.readdata_o         (readdata_o),
		.waitrequest_o      (waitrequest_o),
		.spi_activated_o    (spi_activated),
		.update_frequency_o (update_frequency),
		.pwm_refs_o         (pwm_refs),
		.link_reset_req_o   (link_reset_req)
	);

	myo_frame_scheduler #(
		.NUMBER_OF_MOTORS(NUMBER_OF_MOTORS),
		.CLOCK_SPEED_HZ  (CLOCK_SPEED_HZ)
	) i_frame_scheduler (
		.clock              (clock),
		.reset              (reset),
		.link_reset_i       (link_reset_o),
		.spi_activated_i    (spi_activated),
		.update_frequency_i (update_frequency),
		.pwm_refs_i         (pwm_refs),
		.frame_done_i       (frame_done_i),
		.ss_n_i             (ss_n_i),
		.frame_start_o      (frame_start_o),
		.frame_pwm_o        (frame_pwm_o),
		.ss_n_o             (ss_n_o),
		.latch_o            (latch),
		.latch_motor_o      (latch_motor),
		.active_motor_o     (active_motor),
		.actual_freq_o      (actual_freq)
	);

	myo_sensor_store #(
		.NUMBER_OF_MOTORS(NUMBER_OF_MOTORS)
	) i_sensor_store (
		.clock         (clock),
		.reset         (reset),
		.latch_i       (latch),
		.latch_motor_i (latch_motor),
		.frame_rx_i    (frame_rx_i),
		.mirrored_i    (mirrored_muscle_unit_i),
		.telemetry_o   (telemetry)
	);

	myo_power_sequencer #(
		.POWER_ON_DELAY(POWER_ON_DELAY)
	) i_power_sequencer (
		.clock            (clock),
		.reset            (reset),
		.power_sense_n_i  (power_sense_n_i),
		.link_reset_req_i (link_reset_req),
		.link_reset_o     (link_reset_o),
		.power_good_o     (power_good)
	);

endmodule

`default_nettype wire

// ==== src/myo_frame_scheduler.sv ====
// round-robin frame sequencer, one frame per motor per round
// frame_done_i is a level from the external frame engine, high while it is idle
`default_nettype none

module myo_frame_scheduler #(
	parameter int NUMBER_OF_MOTORS = 6,
	parameter int CLOCK_SPEED_HZ   = 50_000_000
) (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     link_reset_i,
	input  wire logic                     spi_activated_i,
	input  wire logic [31:0]              update_frequency_i,
	input  wire logic [myo_pkg::PWM_W-1:0] pwm_refs_i [NUMBER_OF_MOTORS],
	input  wire logic                     frame_done_i,
	input  wire logic                     ss_n_i,
	output logic                          frame_start_o,
	output logic [myo_pkg::PWM_W-1:0]     frame_pwm_o,
	output logic [NUMBER_OF_MOTORS-1:0]   ss_n_o,
	output logic                          latch_o,
	output myo_pkg::motor_idx_t           latch_motor_o,
	output myo_pkg::motor_idx_t           active_motor_o,
	output logic [31:0]                   actual_freq_o
);
	import myo_pkg::*;

	localparam int SLOT_W = (NUMBER_OF_MOTORS > 1) ? $clog2(NUMBER_OF_MOTORS) : 1;
	localparam motor_idx_t LAST_MOTOR = motor_idx_t'(NUMBER_OF_MOTORS - 1);

	sched_state_e state_q;
	sched_state_e state_d;
	motor_idx_t   motor_q;
	motor_idx_t   motor_d;
	logic         done_prev_q;
	logic         enabled;
	logic         done_rise;
	logic         launch;
	logic         round_start;
	logic [31:0]  pace_q;
	logic [31:0]  pace_load;
	logic [31:0]  round_cnt_q;

	assign enabled   = !link_reset_i && spi_activated_i;
	// the engine raises done when a frame ends, the received data is valid then
	assign done_rise = frame_done_i && !done_prev_q;

	// a free-running round needs no pacing delay
	assign pace_load = (update_frequency_i == '0) ? '0 :
		32'(CLOCK_SPEED_HZ) / update_frequency_i;

	always_comb begin
		state_d = state_q;
		motor_d = motor_q;
		launch  = 1'b0;
		if (!enabled) begin
			state_d = S_IDLE;
			motor_d = '0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (frame_done_i) begin
						state_d = S_IN_FRAME;
						launch  = 1'b1;
					end
				end
				S_IN_FRAME: begin
					if (done_rise) begin
						if (motor_q != LAST_MOTOR) begin
							motor_d = motor_q + 8'd1;
							launch  = 1'b1;
						end else if (update_frequency_i == '0) begin
							motor_d = '0;
							launch  = 1'b1;
						end else begin
							state_d = S_ROUND_WAIT;
						end
					end
				end
				S_ROUND_WAIT: begin
					// the last frame already ended, so done is high here
					if (pace_q == '0 && frame_done_i) begin
						state_d = S_IN_FRAME;
						motor_d = '0;
						launch  = 1'b1;
					end
				end
				default: state_d = S_IDLE;
			endcase
		end
	end

	// every launch of motor 0 opens a new round
	assign round_start = launch && (motor_d == '0);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state_q       <= S_IDLE;
			motor_q       <= '0;
			done_prev_q   <= 1'b0;
			frame_start_o <= 1'b0;
			pace_q        <= '0;
			round_cnt_q   <= '0;
			actual_freq_o <= '0;
		end else begin
			state_q       <= state_d;
			motor_q       <= motor_d;
			done_prev_q   <= frame_done_i;
			frame_start_o <= launch;
			if (round_start) begin
				pace_q      <= pace_load;
				round_cnt_q <= 32'd1;
				// the first round after idle has no previous start to measure from
				if (state_q != S_IDLE) begin
					actual_freq_o <= 32'(CLOCK_SPEED_HZ) / round_cnt_q;
				end
			end else begin
				if (pace_q != '0) begin
					pace_q <= pace_q - 32'd1;
				end
				if (state_q != S_IDLE) begin
					round_cnt_q <= round_cnt_q + 32'd1;
				end
			end
		end
	end

	// motor_q still names the finished motor in the cycle done rises
	assign latch_o        = enabled && (state_q == S_IN_FRAME) && done_rise;
	assign latch_motor_o  = motor_q;
	assign active_motor_o = motor_q;
	assign frame_pwm_o    = pwm_refs_i[motor_q[SLOT_W-1:0]];

	// only the active motor sees the engine's select, all others stay deselected
	always_comb begin
		for (int j = 0; j < NUMBER_OF_MOTORS; j++) begin
			ss_n_o[j] = (motor_q == motor_idx_t'(j)) ? ss_n_i : 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/myo_pkg.sv ====
// shared types and constants for the motor-board SPI controller
// selector codes match the host driver's register map and must not be renumbered
`default_nettype none

package myo_pkg;

	// width of the PWM reference carried in every frame
	localparam int PWM_W = 16;

	// read value for unmapped selectors and motors past the last one
	localparam logic [31:0] READ_DEFAULT = 32'hDEAD_BEEF;

	// motor number as carried in the low address byte
	typedef logic [7:0] motor_idx_t;

	// upper address byte, the register selector
	// some selectors mean something different on write than on read
	typedef enum logic [7:0] {
		// read position, a write requests a link reset
		SEL_POSITION     = 8'h0B,
		// read velocity, a write sets spi_activated
		SEL_VELOCITY     = 8'h0C,
		SEL_CURRENT      = 8'h0D,
		// read displacement, a write sets the update frequency
		SEL_DISPLACEMENT = 8'h0E,
		SEL_PWM_REF      = 8'h0F,
		SEL_ACTUAL_FREQ  = 8'h10,
		SEL_POWER_ON     = 8'h11,
		// read only, the motor the scheduler is serving right now
		SEL_ACTIVE_MOTOR = 8'h12
	} reg_sel_e;

	typedef enum logic [1:0] {
		S_IDLE,
		S_IN_FRAME,
		S_ROUND_WAIT
	} sched_state_e;

	// values returned by the motor board in one frame
	typedef struct packed {
		logic signed [31:0] position;
		logic signed [15:0] velocity;
		logic signed [15:0] current;
		logic signed [15:0] displacement;
	} frame_rx_t;

	// per-motor telemetry as the host sees it, displacement already mirrored
	typedef struct packed {
		logic signed [31:0] position;
		logic signed [15:0] velocity;
		logic signed [15:0] current;
		logic signed [15:0] displacement;
	} telemetry_t;

endpackage

`default_nettype wire

// ==== src/myo_power_sequencer.sv ====
// holds the SPI link in reset until power sense has been active for POWER_ON_DELAY cycles
// power_sense_n_i is taken as already synchronous to clock, POWER_ON_DELAY must be at least 1
`default_nettype none

module myo_power_sequencer #(
	parameter int POWER_ON_DELAY = 150_000_000
) (
	input  wire logic clock,
	input  wire logic reset,
	input  wire logic power_sense_n_i,
	input  wire logic link_reset_req_i,
	output logic      link_reset_o,
	output logic      power_good_o
);
	localparam int CNT_W = $clog2(POWER_ON_DELAY + 1);

	logic [CNT_W-1:0] delay_q;

	// counting restarts whenever the supply drops out
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			delay_q      <= '0;
			power_good_o <= 1'b0;
		end else if (power_sense_n_i) begin
			delay_q      <= '0;
			power_good_o <= 1'b0;
		end else if (delay_q < CNT_W'(POWER_ON_DELAY - 1)) begin
			delay_q <= delay_q + 1'b1;
		end else begin
			// power good rises exactly POWER_ON_DELAY cycles after sense went active
			power_good_o <= 1'b1;
		end
	end

	// a host request adds one reset cycle on top of the power-up hold
	assign link_reset_o = !power_good_o || link_reset_req_i;

endmodule

`default_nettype wire

// ==== src/myo_reg_bank.sv ====
// host register bank, reads take two cycles and writes take one
// any access whose motor byte is at or above NUMBER_OF_MOTORS is ignored or reads 0xDEADBEEF
`default_nettype none

module myo_reg_bank #(
	parameter int NUMBER_OF_MOTORS = 6
) (
	input  wire logic                          clock,
	input  wire logic                          reset,
	input  wire logic [15:0]                   address_i,
	input  wire logic                          read_i,
	input  wire logic                          write_i,
	input  wire logic [31:0]                   writedata_i,
	input  wire logic                          power_sense_n_i,
	input  wire myo_pkg::telemetry_t           telemetry_i [NUMBER_OF_MOTORS],
	input  wire logic [31:0]                   actual_freq_i,
	input  wire myo_pkg::motor_idx_t           active_motor_i,
	input  wire logic                          power_good_i,
	output logic [31:0]                        readdata_o,
	output logic                               waitrequest_o,
	output logic                               spi_activated_o,
	output logic [31:0]                        update_frequency_o,
	output logic [myo_pkg::PWM_W-1:0]          pwm_refs_o [NUMBER_OF_MOTORS],
	output logic                               link_reset_req_o
);
	import myo_pkg::*;

	localparam int SLOT_W = (NUMBER_OF_MOTORS > 1) ? $clog2(NUMBER_OF_MOTORS) : 1;

	reg_sel_e         sel;
	motor_idx_t       motor;
	logic [SLOT_W-1:0] slot;
	logic             in_range;
	logic             read_done_q;
	logic             write_en;
	logic [31:0]      read_mux;
	telemetry_t       tel;

	// the 16 bit fields are signed, so they are sign extended onto the bus
	function automatic logic [31:0] sext16(input logic [15:0] value);
		return {{16{value[15]}}, value};
	endfunction

	// upper byte picks the register, lower byte picks the motor
	assign sel      = reg_sel_e'(address_i[15:8]);
	assign motor    = address_i[7:0];
	assign slot     = motor[SLOT_W-1:0];
	assign in_range = (motor < motor_idx_t'(NUMBER_OF_MOTORS));

	// first cycle of a read stalls the host, the second one returns the data
	assign waitrequest_o = read_i && !read_done_q;
	assign write_en      = write_i && !waitrequest_o && in_range;

	always_comb begin
		tel      = telemetry_i[slot];
		read_mux = READ_DEFAULT;
		if (in_range) begin
			case (sel)
				SEL_POSITION:     read_mux = tel.position;
				SEL_VELOCITY:     read_mux = sext16(tel.velocity);
				SEL_CURRENT:      read_mux = sext16(tel.current);
				SEL_DISPLACEMENT: read_mux = sext16(tel.displacement);
				SEL_PWM_REF:      read_mux = sext16(pwm_refs_o[slot]);
				SEL_ACTUAL_FREQ:  read_mux = actual_freq_i;
				// power sense pin is active low
				SEL_POWER_ON:     read_mux = {31'd0, !power_sense_n_i};
				SEL_ACTIVE_MOTOR: read_mux = {24'd0, active_motor_i};
				default:          read_mux = READ_DEFAULT;
			endcase
		end
	end

	// read_done_q marks the second cycle, so a held read restarts after it
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_done_q <= 1'b0;
		end else begin
			read_done_q <= read_i && !read_done_q;
		end
	end

	// data is captured in the stall cycle and presented when the stall drops
	always_ff @(posedge clock) begin
		if (read_i && !read_done_q) begin
			readdata_o <= read_mux;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			spi_activated_o    <= 1'b0;
			update_frequency_o <= '0;
			link_reset_req_o   <= 1'b0;
			// motors start with zero drive
			for (int m = 0; m < NUMBER_OF_MOTORS; m++) begin
				pwm_refs_o[m] <= '0;
			end
		end else begin
			// the request is a single cycle pulse
			link_reset_req_o <= 1'b0;
			if (write_en) begin
				case (sel)
					SEL_POSITION:     link_reset_req_o <= 1'b1;
					SEL_VELOCITY:     spi_activated_o <= (writedata_i != '0);
					SEL_DISPLACEMENT: update_frequency_o <= writedata_i;
					SEL_PWM_REF:      pwm_refs_o[slot] <= writedata_i[PWM_W-1:0];
					default:          ;
				endcase
			end
			// once power is good the link runs no matter what the host wrote
			if (power_good_i) begin
				spi_activated_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/myo_sensor_store.sv ====
// per-motor telemetry, loaded on the clock edge that ends the latch strobe
// frame_rx_i must be valid in the strobe cycle
`default_nettype none

module myo_sensor_store #(
	parameter int NUMBER_OF_MOTORS = 6
) (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               latch_i,
	input  wire myo_pkg::motor_idx_t latch_motor_i,
	input  wire myo_pkg::frame_rx_t frame_rx_i,
	input  wire logic               mirrored_i,
	output myo_pkg::telemetry_t     telemetry_o [NUMBER_OF_MOTORS]
);
	import myo_pkg::*;

	telemetry_t captured;

	// a mirrored unit is mounted the other way round, so its spring reads negative
	always_comb begin
		captured.position     = frame_rx_i.position;
		captured.velocity     = frame_rx_i.velocity;
		captured.current      = frame_rx_i.current;
		captured.displacement = mirrored_i ? -frame_rx_i.displacement : frame_rx_i.displacement;
	end

	// reads before the first frame of a motor return zero
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int m = 0; m < NUMBER_OF_MOTORS; m++) begin
				telemetry_o[m] <= '0;
			end
		end else if (latch_i) begin
			// only the slot of the motor that just finished changes
			for (int m = 0; m < NUMBER_OF_MOTORS; m++) begin
				if (latch_motor_i == motor_idx_t'(m)) begin
					telemetry_o[m] <= captured;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/myo_control_asserts.sv ====
// protocol checks on the frame port and the host bus, bound into the controller top
`default_nettype none

module myo_control_asserts #(
	parameter int NUMBER_OF_MOTORS = 6
) (
	input wire logic                        clock,
	input wire logic                        reset,
	input wire logic                        frame_start_o,
	input wire logic                        frame_done_i,
	input wire logic [NUMBER_OF_MOTORS-1:0] ss_n_o,
	input wire logic                        read_i,
	input wire logic                        waitrequest_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// the start pulse is registered, so done was high in the cycle before it
	assert property (@(posedge clock) disable iff (reset)
		frame_start_o |-> $past(frame_done_i))
		else $error("frame start issued while the engine was busy");

	assert property (@(posedge clock) disable iff (reset)
		$countones(~ss_n_o) <= 1)
		else $error("more than one slave select active");

	// a read has exactly one wait state
	assert property (@(posedge clock) disable iff (reset)
		(read_i && waitrequest_o) |=> !waitrequest_o)
		else $error("waitrequest high for two cycles of one read");

endmodule

bind myo_control_top myo_control_asserts #(
	.NUMBER_OF_MOTORS(NUMBER_OF_MOTORS)
) i_myo_control_asserts (
	.clock         (clock),
	.reset         (reset),
	.frame_start_o (frame_start_o),
	.frame_done_i  (frame_done_i),
	.ss_n_o        (ss_n_o),
	.read_i        (read_i),
	.waitrequest_o (waitrequest_o)
);

`default_nettype wire

// ==== verif/tb_myo_control.sv ====
// testbench for myo_control_top with a behavioral model of the external frame engine
// four motors, a 1 kHz nominal clock rate for the frequency math, 20 cycle power-on delay
`default_nettype none

module tb_myo_control;
	timeunit 1ns;
	timeprecision 1ps;
	import myo_pkg::*;

	localparam int N_MOTORS    = 4;
	localparam int CLK_HZ      = 1000;
	localparam int PWR_DELAY   = 20;
	// a pacing delay of 100 cycles outlasts any free-running round of four frames
	localparam int PACE_HZ     = 10;
	// about 20 free-running rounds of up to 45 cycles and 5 paced rounds of 101, wide margin
	localparam int CYCLE_LIMIT = 20000;

	logic                  clock;
	logic                  reset;
	logic [15:0]           address_i;
	logic                  read_i;
	logic                  write_i;
	logic [31:0]           writedata_i;
	logic                  frame_done_i;
	frame_rx_t             frame_rx_i;
	logic                  ss_n_i;
	logic                  mirrored_muscle_unit_i;
	logic                  power_sense_n_i;
	logic [31:0]           readdata_o;
	logic                  waitrequest_o;
	logic                  frame_start_o;
	logic [PWM_W-1:0]      frame_pwm_o;
	logic                  link_reset_o;
	logic [N_MOTORS-1:0]   ss_n_o;

	logic [31:0]      rng_state;
	int               cycle;
	// waitrequest as it was in the cycle before the last rising edge
	logic             waitrequest_seen;
	// reference model of what the host should see
	logic [PWM_W-1:0] model_pwm [N_MOTORS];
	telemetry_t       model_tel [N_MOTORS];
	int               exp_motor;
	int               cur_motor;
	int               frames_started;
	int               rounds_started;
	int               first_start_cycle;
	int               last_round_cycle;
	int               last_period;
	int               sense_cycle;
	logic             mirror_req;
	logic             pace_check;
	logic             order_check;

	myo_control_top #(
		.NUMBER_OF_MOTORS(N_MOTORS),
		.CLOCK_SPEED_HZ  (CLK_HZ),
		.POWER_ON_DELAY  (PWR_DELAY)
	) i_myo_control_top (
		.clock                  (clock),
		.reset                  (reset),
		.address_i              (address_i),
		.read_i                 (read_i),
		.write_i                (write_i),
		.writedata_i            (writedata_i),
		.frame_done_i           (frame_done_i),
		.frame_rx_i             (frame_rx_i),
		.ss_n_i                 (ss_n_i),
		.mirrored_muscle_unit_i (mirrored_muscle_unit_i),
		.power_sense_n_i        (power_sense_n_i),
		.readdata_o             (readdata_o),
		.waitrequest_o          (waitrequest_o),
		.frame_start_o          (frame_start_o),
		.frame_pwm_o            (frame_pwm_o),
		.link_reset_o           (link_reset_o),
		.ss_n_o                 (ss_n_o)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		waitrequest_seen <= waitrequest_o;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// 16 bit registers are signed and reach the bus sign extended
	function automatic logic [31:0] sign_extend16(input logic [15:0] value);
		return {{16{value[15]}}, value};
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h",
				name, expected, actual));
		end
	endtask

	task automatic check_ss(input string name, input logic [N_MOTORS-1:0] expected,
			input logic [N_MOTORS-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH %s expected %b actual %b",
				name, expected, actual));
		end
	endtask

	task automatic check_pwm(input string name, input logic [PWM_W-1:0] expected,
			input logic [PWM_W-1:0] actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("MISMATCH %s expected 0x%04h actual 0x%04h",
				name, expected, actual));
		end
	endtask

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			stop_with_failure("timeout, the test did not finish within the cycle limit");
		end
	end

	// the engine holds done low for 3 to 10 cycles, then returns fresh sensor data
	task automatic run_frame();
		int        m;
		int        len;
		frame_rx_t rx;
		m = exp_motor;
		frame_done_i = 1'b0;
		ss_n_i = 1'b0;
		if (frames_started == 0) begin
			first_start_cycle = cycle;
		end
		frames_started++;
		if (order_check) begin
			check_pwm("frame pwm", model_pwm[m], frame_pwm_o);
			if (m == 0) begin
				if (rounds_started > 0) begin
					last_period = cycle - last_round_cycle;
					if (pace_check && last_period < CLK_HZ / PACE_HZ) begin
						stop_with_failure("paced round was shorter than the pacing delay");
					end
				end
				last_round_cycle = cycle;
				rounds_started++;
			end
		end
		cur_motor = m;
		len = 3 + int'(xorshift32() % 8);
		@(negedge clock);
		if (order_check) begin
			check_ss("active select", ~(N_MOTORS'(1) << m), ss_n_o);
		end
		repeat (len - 1) @(negedge clock);
		rx.position     = xorshift32();
		rx.velocity     = 16'(xorshift32());
		rx.current      = 16'(xorshift32());
		rx.displacement = 16'(xorshift32());
		// the mirror pin only changes here so the latch sees a settled value
		mirrored_muscle_unit_i = mirror_req;
		model_tel[m].position     = rx.position;
		model_tel[m].velocity     = rx.velocity;
		model_tel[m].current      = rx.current;
		model_tel[m].displacement = mirror_req ? -rx.displacement : rx.displacement;
		frame_rx_i   = rx;
		ss_n_i       = 1'b1;
		frame_done_i = 1'b1;
		exp_motor    = (m + 1) % N_MOTORS;
	endtask

	always begin
		@(negedge clock);
		if (!reset) begin
			// between frames no motor may be selected
			check_ss("idle select", '1, ss_n_o);
			if (frame_start_o) begin
				run_frame();
			end
		end
	end

	// called on a falling edge, returns on the falling edge after the write took effect
	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
		address_i   = addr;
		writedata_i = data;
		write_i     = 1'b1;
		@(posedge clock);
		if (addr[15:8] == SEL_PWM_REF && addr[7:0] < N_MOTORS) begin
			model_pwm[addr[7:0]] = data[PWM_W-1:0];
		end
		@(negedge clock);
		write_i = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
		int waited;
		waited    = 0;
		address_i = addr;
		read_i    = 1'b1;
		@(negedge clock);
		// the first cycle of every read must stall the host
		check_word("read first cycle stall", 32'd1, {31'd0, waitrequest_seen});
		while (waitrequest_o) begin
			waited++;
			if (waited > 4) begin
				stop_with_failure("read never completed, waitrequest stayed high");
			end
			@(negedge clock);
		end
		data   = readdata_o;
		read_i = 1'b0;
		check_word("read wait states", 32'd0, 32'(waited));
		// one idle cycle so back to back reads stay separate transactions
		@(negedge clock);
	endtask

	task automatic wait_frames(input int target);
		while (frames_started < target) @(negedge clock);
	endtask

	task automatic wait_rounds(input int target);
		while (rounds_started < target) @(negedge clock);
	endtask

	initial begin
		logic [31:0] rd;
		logic [31:0] data;
		logic [7:0]  motor;
		int          m;
		address_i = '0;
		read_i = 1'b0;
		write_i = 1'b0;
		writedata_i = '0;
		frame_done_i = 1'b1;
		frame_rx_i = '0;
		ss_n_i = 1'b1;
		mirrored_muscle_unit_i = 1'b0;
		power_sense_n_i = 1'b1;
		rng_state = 32'd54725;
		cycle = 0;
		exp_motor = 0;
		cur_motor = 0;
		frames_started = 0;
		rounds_started = 0;
		first_start_cycle = 0;
		last_round_cycle = 0;
		last_period = 0;
		mirror_req = 1'b0;
		pace_check = 1'b0;
		order_check = 1'b1;
		for (int i = 0; i < N_MOTORS; i++) begin
			model_pwm[i] = '0;
			model_tel[i] = '0;
		end
		reset = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// power sense still inactive, the link must stay in reset
		repeat (10) @(negedge clock);
		if (frames_started != 0) begin
			stop_with_failure("a frame started while power sense was inactive");
		end
		check_word("link reset before power", 32'd1, {31'd0, link_reset_o});
		power_sense_n_i = 1'b0;
		sense_cycle = cycle;
		wait_frames(1);
		if (first_start_cycle - sense_cycle < PWR_DELAY) begin
			stop_with_failure("first frame started before the power-on delay had passed");
		end
		bus_read({SEL_POWER_ON, 8'd0}, rd);
		check_word("power on", 32'd1, rd);

		// PWM references, in range and out of range
		for (int i = 0; i < 16; i++) begin
			motor = 8'(xorshift32() % N_MOTORS);
			data  = xorshift32();
			bus_write({SEL_PWM_REF, motor}, data);
			bus_read({SEL_PWM_REF, motor}, rd);
			check_word("pwm readback", sign_extend16(data[15:0]), rd);
		end
		for (int i = 0; i < 6; i++) begin
			motor = 8'(4 + xorshift32() % 252);
			bus_write({SEL_PWM_REF, motor}, xorshift32());
			bus_read({SEL_PWM_REF, motor}, rd);
			check_word("pwm out of range", READ_DEFAULT, rd);
		end
		for (int i = 0; i < N_MOTORS; i++) begin
			bus_read({SEL_PWM_REF, 8'(i)}, rd);
			check_word("pwm unchanged", sign_extend16(model_pwm[i]), rd);
		end

		// telemetry of the motor that finished just before the current frame
		for (int i = 0; i < 24; i++) begin
			if (i == 12) begin
				mirror_req = 1'b1;
			end
			wait_frames(frames_started + 1);
			m = (cur_motor + N_MOTORS - 1) % N_MOTORS;
			bus_read({SEL_POSITION, 8'(m)}, rd);
			check_word("position", model_tel[m].position, rd);
			bus_read({SEL_VELOCITY, 8'(m)}, rd);
			check_word("velocity", sign_extend16(model_tel[m].velocity), rd);
			bus_read({SEL_CURRENT, 8'(m)}, rd);
			check_word("current", sign_extend16(model_tel[m].current), rd);
			bus_read({SEL_DISPLACEMENT, 8'(m)}, rd);
			check_word("displacement", sign_extend16(model_tel[m].displacement), rd);
		end

		// measured round frequency, free running and then paced at PACE_HZ
		for (int i = 0; i < 8; i++) begin
			if (i == 4) begin
				bus_write({SEL_DISPLACEMENT, 8'd0}, PACE_HZ);
				// the round already running was loaded without a pacing delay
				wait_rounds(rounds_started + 1);
				pace_check = 1'b1;
			end
			wait_rounds(rounds_started + 1);
			bus_read({SEL_ACTUAL_FREQ, 8'd0}, rd);
			if (rounds_started >= 2) begin
				check_word("actual frequency", 32'(CLK_HZ / last_period), rd);
			end
		end

		// host link reset, the scheduler restarts so order checks stop here
		order_check = 1'b0;
		bus_write({SEL_POSITION, 8'd0}, 32'd0);
		check_word("link reset pulse", 32'd1, {31'd0, link_reset_o});
		@(negedge clock);
		check_word("link reset released", 32'd0, {31'd0, link_reset_o});
		bus_read({SEL_POWER_ON, 8'd0}, rd);
		check_word("power on after link reset", 32'd1, rd);

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/myo_pkg.sv
src/myo_reg_bank.sv
src/myo_sensor_store.sv
src/myo_frame_scheduler.sv
src/myo_power_sequencer.sv
src/myo_control_top.sv
verif/myo_control_asserts.sv
verif/tb_myo_control.sv
